// File: bench/ao_periph_asserts.sv
//**************************************************************************
// Slave port protocol and reset assertions, bound to the subsystem top
//**************************************************************************
`timescale 1ns/1ps

module ao_periph_asserts
  import ao_periph_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_i,
  input logic       gnt_o,
  input logic       rvalid_o,
  input logic       exit_valid_o,
  input fast_intr_t fast_intr_o
);

  int err_cnt = 0;

  // Response in exactly the cycle after each grant
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_o |=> rvalid_o)
    else begin
      $error("rvalid_o missing in the cycle after a grant");
      err_cnt = err_cnt + 1;
    end

  a_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> $past(gnt_o))
    else begin
      $error("rvalid_o without a grant in the previous cycle");
      err_cnt = err_cnt + 1;
    end

  a_no_gnt_in_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(gnt_o && rvalid_o))
    else begin
      $error("gnt_o high while rvalid_o is high");
      err_cnt = err_cnt + 1;
    end

  a_gnt_needs_req: assert property (@(posedge clk_i) gnt_o |-> req_i)
    else begin
      $error("gnt_o high without req_i");
      err_cnt = err_cnt + 1;
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !rvalid_o && !exit_valid_o && (fast_intr_o == '0))
    else begin
      $error("outputs not low in the first cycle after reset");
      err_cnt = err_cnt + 1;
    end

endmodule : ao_periph_asserts

bind ao_peripheral_subsystem ao_periph_asserts i_ao_periph_asserts (.*);

// File: bench/tb_ao_peripheral_subsystem.sv
//**************************************************************************
// Directed testbench for the always-on peripheral subsystem
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  ao_strb_t    be_i;
  ao_data_t    wdata_i;
  logic        gnt_o;
  logic        rvalid_o;
  ao_data_t    rdata_o;
  logic        boot_select_i;
  logic        exit_valid_o;
  ao_data_t    exit_value_o;
  fast_intr_t  fast_intr_i;
  fast_intr_t  fast_intr_o;
  gpio_t       cio_gpio_i;
  gpio_t       cio_gpio_o;
  gpio_t       cio_gpio_en_o;
  gpio_t       intr_gpio_o;

  integer   seed = 32'hf165;
  int       pass_cnt = 0;
  int       fail_cnt = 0;
  int       cycle_cnt = 0;
  // Register contents the tests expect to survive later accesses
  ao_data_t scratch_model;
  ao_data_t exit_value_model;
  gpio_t    gpio_out_model;

  ao_peripheral_subsystem i_ao_peripheral_subsystem (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_value(input string name, input ao_data_t exp_val,
                             input ao_data_t act_val);
    assert (act_val === exp_val) begin
      pass_cnt++;
    end else begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp_val, act_val);
      fail_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, fail_cnt - errs_before);
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // Returns at the falling edge of the cycle where the signal is high
  task automatic wait_handshake(input bit want_rvalid, output int at_cycle);
    int   waited;
    logic seen;
    waited = 0;
    @(negedge clk_i);
    seen = want_rvalid ? rvalid_o : gnt_o;
    while (!seen && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      seen = want_rvalid ? rvalid_o : gnt_o;
      waited++;
    end
    if (!seen) begin
      $display("ERROR: %s did not rise within %0d cycles",
               want_rvalid ? "rvalid_o" : "gnt_o", TIMEOUT_CYCLES);
      fail_cnt++;
    end
    at_cycle = cycle_cnt;
  endtask

  // Random upper address bits that the subsystem ignores
  task automatic bus_transfer(input logic we, input ao_addr_t addr, input ao_data_t wdata,
                              input ao_strb_t be, output ao_data_t rdata);
    int          gnt_cycle;
    int          rsp_cycle;
    logic [31:0] upper;
    upper = $random(seed);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= {upper[31:12], addr};
    be_i    <= be;
    wdata_i <= wdata;
    wait_handshake(1'b0, gnt_cycle);
    @(posedge clk_i);
    req_i <= 1'b0;
    wait_handshake(1'b1, rsp_cycle);
    check_value("rvalid_o latency", gnt_cycle + 1, rsp_cycle);
    rdata = rdata_o;
  endtask

  task automatic bus_write(input ao_addr_t addr, input ao_data_t wdata, input ao_strb_t be);
    ao_data_t rd;
    bus_transfer(1'b1, addr, wdata, be, rd);
    check_value("rdata_o on write", '0, rd);
  endtask

  task automatic bus_read(input ao_addr_t addr, output ao_data_t rdata);
    bus_transfer(1'b0, addr, '0, 4'hF, rdata);
  endtask

  // Expected word after a write with byte enables
  function automatic ao_data_t apply_strobes(ao_data_t old_val, ao_data_t new_val,
                                             ao_strb_t be);
    ao_data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic test_reset_readback();
    ao_data_t rd;
    int       errs;
    errs = fail_cnt;
    check_value("exit_valid_o", '0, exit_valid_o);
    check_value("fast_intr_o", '0, fast_intr_o);
    check_value("cio_gpio_o", '0, cio_gpio_o);
    check_value("cio_gpio_en_o", '0, cio_gpio_en_o);
    check_value("intr_gpio_o", '0, intr_gpio_o);
    for (int sel = 0; sel < 2; sel++) begin
      @(posedge clk_i);
      boot_select_i <= sel[0];
      bus_read(`AO_SOC_CTRL_BASE + `SOC_BOOT_SEL_OFS, rd);
      check_value("rdata_o BOOT_SEL", sel, rd);
    end
    report_test("reset_readback", errs);
  endtask

  task automatic test_soc_ctrl();
    ao_data_t val;
    ao_data_t new_val;
    ao_data_t rd;
    ao_strb_t be;
    int       errs;
    errs = fail_cnt;
    val = $random(seed);
    bus_write(`AO_SOC_CTRL_BASE + `SOC_EXIT_VALUE_OFS, val, 4'hF);
    exit_value_model = val;
    skip_cycles(1);
    check_value("exit_value_o", val, exit_value_o);
    bus_read(`AO_SOC_CTRL_BASE + `SOC_EXIT_VALUE_OFS, rd);
    check_value("rdata_o EXIT_VALUE", val, rd);
    bus_write(`AO_SOC_CTRL_BASE + `SOC_EXIT_VALID_OFS, 32'h1, 4'hF);
    skip_cycles(1);
    check_value("exit_valid_o", 32'h1, exit_valid_o);
    // Partial strobe write over a known scratch word
    val = $random(seed);
    new_val = $random(seed);
    be = $random(seed);
    if (be == 4'h0 || be == 4'hF) begin
      be = 4'b1001;
    end
    bus_write(`AO_SOC_CTRL_BASE + `SOC_SCRATCH_OFS, val, 4'hF);
    bus_write(`AO_SOC_CTRL_BASE + `SOC_SCRATCH_OFS, new_val, be);
    scratch_model = apply_strobes(val, new_val, be);
    bus_read(`AO_SOC_CTRL_BASE + `SOC_SCRATCH_OFS, rd);
    check_value("rdata_o SCRATCH", scratch_model, rd);
    report_test("soc_ctrl", errs);
  endtask

  task automatic test_fast_intr();
    fast_intr_t bit_mask;
    ao_data_t   rd;
    int         idx;
    int         errs;
    errs = fail_cnt;
    idx = {$random(seed)} % `AO_NUM_FAST_INTR;
    bit_mask = fast_intr_t'(1) << idx;
    @(posedge clk_i);
    fast_intr_i <= bit_mask;
    @(posedge clk_i);
    fast_intr_i <= '0;
    bus_read(`AO_FAST_INTR_BASE + `FIC_PENDING_OFS, rd);
    check_value("rdata_o PENDING", bit_mask, rd);
    check_value("fast_intr_o", '0, fast_intr_o);
    bus_write(`AO_FAST_INTR_BASE + `FIC_ENABLE_OFS, bit_mask, 4'hF);
    skip_cycles(1);
    check_value("fast_intr_o", bit_mask, fast_intr_o);
    bus_write(`AO_FAST_INTR_BASE + `FIC_PENDING_OFS, bit_mask, 4'hF);
    skip_cycles(1);
    check_value("fast_intr_o", '0, fast_intr_o);
    bus_read(`AO_FAST_INTR_BASE + `FIC_PENDING_OFS, rd);
    check_value("rdata_o PENDING", '0, rd);
    report_test("fast_intr", errs);
  endtask

  task automatic test_gpio();
    gpio_t    out_val;
    gpio_t    en_val;
    gpio_t    pin_val;
    gpio_t    bit_mask;
    ao_data_t rd;
    int       idx;
    int       errs;
    errs = fail_cnt;
    out_val = $random(seed);
    en_val = $random(seed);
    bus_write(`AO_GPIO_BASE + `GPIO_OUT_OFS, out_val, 4'hF);
    gpio_out_model = out_val;
    bus_write(`AO_GPIO_BASE + `GPIO_OUT_EN_OFS, en_val, 4'hF);
    skip_cycles(1);
    check_value("cio_gpio_o", out_val, cio_gpio_o);
    check_value("cio_gpio_en_o", en_val, cio_gpio_en_o);
    pin_val = $random(seed);
    @(posedge clk_i);
    cio_gpio_i <= pin_val;
    skip_cycles(2);
    bus_read(`AO_GPIO_BASE + `GPIO_IN_OFS, rd);
    check_value("rdata_o IN", pin_val, rd);
    // Pins low before clearing edges left from the random input
    idx = {$random(seed)} % `AO_NUM_GPIO;
    bit_mask = gpio_t'(1) << idx;
    @(posedge clk_i);
    cio_gpio_i <= '0;
    skip_cycles(4);
    bus_write(`AO_GPIO_BASE + `GPIO_INTR_STATUS_OFS, 32'hFF, 4'hF);
    bus_write(`AO_GPIO_BASE + `GPIO_INTR_EN_OFS, bit_mask, 4'hF);
    skip_cycles(1);
    check_value("intr_gpio_o", '0, intr_gpio_o);
    @(posedge clk_i);
    cio_gpio_i <= bit_mask;
    // Two synchronizer edges plus one for the edge detector
    skip_cycles(4);
    check_value("intr_gpio_o", bit_mask, intr_gpio_o);
    bus_read(`AO_GPIO_BASE + `GPIO_INTR_STATUS_OFS, rd);
    check_value("rdata_o INTR_STATUS", bit_mask, rd);
    bus_write(`AO_GPIO_BASE + `GPIO_INTR_STATUS_OFS, bit_mask, 4'hF);
    skip_cycles(1);
    check_value("intr_gpio_o", '0, intr_gpio_o);
    bus_read(`AO_GPIO_BASE + `GPIO_INTR_STATUS_OFS, rd);
    check_value("rdata_o INTR_STATUS", '0, rd);
    report_test("gpio", errs);
  endtask

  task automatic test_unmapped();
    ao_data_t rd;
    ao_data_t junk;
    int       errs;
    errs = fail_cnt;
    bus_read(12'h300, rd);
    check_value("rdata_o unmapped", `AO_BAD_ADDR_DATA, rd);
    junk = $random(seed);
    bus_write(12'h300 + `SOC_SCRATCH_OFS, junk, 4'hF);
    bus_write(12'h300 + `SOC_EXIT_VALUE_OFS, ~junk, 4'hF);
    skip_cycles(1);
    check_value("exit_value_o", exit_value_model, exit_value_o);
    check_value("cio_gpio_o", gpio_out_model, cio_gpio_o);
    bus_read(`AO_SOC_CTRL_BASE + `SOC_SCRATCH_OFS, rd);
    check_value("rdata_o SCRATCH", scratch_model, rd);
    report_test("unmapped", errs);
  endtask

  // Write then read with req_i held high between the two
  task automatic test_back_to_back();
    ao_data_t wval;
    int       gnt_cycle;
    int       rsp_cycle;
    int       errs;
    errs = fail_cnt;
    wval = $random(seed);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= `AO_SOC_CTRL_BASE + `SOC_SCRATCH_OFS;
    be_i    <= 4'hF;
    wdata_i <= wval;
    for (int n = 0; n < 2; n++) begin
      wait_handshake(1'b0, gnt_cycle);
      @(posedge clk_i);
      if (n == 0) begin
        we_i    <= 1'b0;
        wdata_i <= '0;
      end else begin
        req_i <= 1'b0;
      end
      wait_handshake(1'b1, rsp_cycle);
      check_value("rvalid_o latency", gnt_cycle + 1, rsp_cycle);
      check_value("gnt_o during rvalid_o", '0, gnt_o);
    end
    check_value("rdata_o SCRATCH", wval, rdata_o);
    report_test("back_to_back", errs);
  endtask

  initial begin
    rst_n_i       = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    be_i          = '0;
    wdata_i       = '0;
    boot_select_i = 1'b0;
    fast_intr_i   = '0;
    cio_gpio_i    = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    test_reset_readback();
    test_soc_ctrl();
    test_fast_intr();
    test_gpio();
    test_unmapped();
    test_back_to_back();
    // Protocol assertion failures count as failed checks
    fail_cnt = fail_cnt + i_ao_peripheral_subsystem.i_ao_periph_asserts.err_cnt;
    $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

// File: compile.f
+incdir+src
src/ao_periph_pkg.sv
src/obi_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/fast_intr_ctrl.sv
src/gpio_ao.sv
src/ao_peripheral_subsystem.sv
bench/ao_periph_asserts.sv
bench/tb_ao_peripheral_subsystem.sv

// File: src/ao_periph_macros.svh
//**************************************************************************
// Always-on peripheral widths, block address map and register offsets
//**************************************************************************
`ifndef AO_PERIPH_MACROS_SVH
`define AO_PERIPH_MACROS_SVH

`define AO_DATA_W          32
`define AO_ADDR_W          12
`define AO_NUM_FAST_INTR   15
`define AO_NUM_GPIO        8

// Block bases, decoded from offset bits 11 to 8
`define AO_SOC_CTRL_BASE   12'h000
`define AO_FAST_INTR_BASE  12'h100
`define AO_GPIO_BASE       12'h200

`define SOC_EXIT_VALID_OFS 8'h00
`define SOC_EXIT_VALUE_OFS 8'h04
`define SOC_BOOT_SEL_OFS   8'h08
`define SOC_SCRATCH_OFS    8'h0C

`define FIC_PENDING_OFS    8'h00
`define FIC_ENABLE_OFS     8'h04

`define GPIO_IN_OFS          8'h00
`define GPIO_OUT_OFS         8'h04
`define GPIO_OUT_EN_OFS      8'h08
`define GPIO_INTR_EN_OFS     8'h0C
`define GPIO_INTR_STATUS_OFS 8'h10

// Read data for offsets outside every block
`define AO_BAD_ADDR_DATA   32'hBADCAB1E

`endif

// File: src/ao_periph_pkg.sv
//**************************************************************************
// Shared types of the always-on peripheral subsystem
//**************************************************************************
`include "ao_periph_macros.svh"

package ao_periph_pkg;

  typedef logic [`AO_DATA_W-1:0]        ao_data_t;
  typedef logic [`AO_ADDR_W-1:0]        ao_addr_t;
  typedef logic [`AO_DATA_W/8-1:0]      ao_strb_t;
  typedef logic [`AO_NUM_FAST_INTR-1:0] fast_intr_t;
  typedef logic [`AO_NUM_GPIO-1:0]      gpio_t;

  typedef enum logic {
    BRIDGE_IDLE,
    BRIDGE_RESP
  } bridge_state_e;

  // Expands byte strobes into a bit mask over the data word
  function automatic ao_data_t strb_mask(ao_strb_t strb);
    ao_data_t mask;
    mask = '0;
    for (int b = 0; b < `AO_DATA_W/8; b++) begin
      if (strb[b]) begin
        mask[8*b +: 8] = 8'hFF;
      end
    end
    return mask;
  endfunction

endpackage : ao_periph_pkg

// File: src/ao_peripheral_subsystem.sv
//**************************************************************************
// Always-on peripheral subsystem: bridge, decoder and register blocks
//**************************************************************************
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Slave port
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  ao_strb_t    be_i,
  input  ao_data_t    wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output ao_data_t    rdata_o,

  // System control
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output ao_data_t    exit_value_o,

  // Fast interrupts
  input  fast_intr_t  fast_intr_i,
  output fast_intr_t  fast_intr_o,

  // GPIO
  input  gpio_t       cio_gpio_i,
  output gpio_t       cio_gpio_o,
  output gpio_t       cio_gpio_en_o,
  output gpio_t       intr_gpio_o
);

  logic     reg_valid;
  logic     reg_write;
  ao_addr_t reg_addr;
  ao_data_t reg_wdata;
  ao_strb_t reg_strb;
  ao_data_t reg_rdata;

  logic     soc_valid;
  logic     fic_valid;
  logic     gpio_valid;
  ao_data_t soc_rdata;
  ao_data_t fic_rdata;
  ao_data_t gpio_rdata;

  obi_to_reg i_obi_to_reg (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_strb_o  (reg_strb),
    .reg_rdata_i (reg_rdata)
  );

  reg_demux i_reg_demux (
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_rdata_o  (reg_rdata),
    .soc_valid_o  (soc_valid),
    .fic_valid_o  (fic_valid),
    .gpio_valid_o (gpio_valid),
    .soc_rdata_i  (soc_rdata),
    .fic_rdata_i  (fic_rdata),
    .gpio_rdata_i (gpio_rdata)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .valid_i (soc_valid),
    .write_i (reg_write),
    .addr_i  (reg_addr),
    .wdata_i (reg_wdata),
    .strb_i  (reg_strb),
    .rdata_o (soc_rdata),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl i_fast_intr_ctrl (
    .clk_i,
    .rst_n_i,
    .valid_i (fic_valid),
    .write_i (reg_write),
    .addr_i  (reg_addr),
    .wdata_i (reg_wdata),
    .strb_i  (reg_strb),
    .rdata_o (fic_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao i_gpio_ao (
    .clk_i,
    .rst_n_i,
    .valid_i (gpio_valid),
    .write_i (reg_write),
    .addr_i  (reg_addr),
    .wdata_i (reg_wdata),
    .strb_i  (reg_strb),
    .rdata_o (gpio_rdata),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule : ao_peripheral_subsystem

// File: src/fast_intr_ctrl.sv
//**************************************************************************
// Fast interrupt controller with pending latch and enable mask
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  input  logic       valid_i,
  input  logic       write_i,
  input  ao_addr_t   addr_i,
  input  ao_data_t   wdata_i,
  input  ao_strb_t   strb_i,
  output ao_data_t   rdata_o,

  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o
);

  logic       wr_en;
  ao_data_t   wmask;
  ao_data_t   wbits;
  fast_intr_t pending_clr;

  fast_intr_t pending_q;
  fast_intr_t enable_q;

  assign wr_en = valid_i && write_i;
  assign wmask = strb_mask(strb_i);
  assign wbits = wdata_i & wmask;

  // Write one to clear
  assign pending_clr = (wr_en && addr_i[7:0] == `FIC_PENDING_OFS) ?
                       wbits[`AO_NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A set in the same cycle wins over the clear
      pending_q <= (pending_q & ~pending_clr) | fast_intr_i;
      if (wr_en && addr_i[7:0] == `FIC_ENABLE_OFS) begin
        enable_q <= (enable_q & ~wmask[`AO_NUM_FAST_INTR-1:0]) | wbits[`AO_NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (addr_i[7:0])
      `FIC_PENDING_OFS: rdata_o = ao_data_t'(pending_q);
      `FIC_ENABLE_OFS:  rdata_o = ao_data_t'(enable_q);
      default: ;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

// File: src/gpio_ao.sv
//**************************************************************************
// Always-on GPIO with synchronized inputs and rising-edge interrupts
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module gpio_ao
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     valid_i,
  input  logic     write_i,
  input  ao_addr_t addr_i,
  input  ao_data_t wdata_i,
  input  ao_strb_t strb_i,
  output ao_data_t rdata_o,

  input  gpio_t    cio_gpio_i,
  output gpio_t    cio_gpio_o,
  output gpio_t    cio_gpio_en_o,
  output gpio_t    intr_gpio_o
);

  logic     wr_en;
  ao_data_t wmask;
  ao_data_t wbits;
  gpio_t    gpio_rise;
  gpio_t    status_clr;

  gpio_t    gpio_meta_q;
  gpio_t    gpio_in_q;
  gpio_t    gpio_last_q;
  gpio_t    out_q;
  gpio_t    out_en_q;
  gpio_t    intr_en_q;
  gpio_t    status_q;

  assign wr_en = valid_i && write_i;
  assign wmask = strb_mask(strb_i);
  assign wbits = wdata_i & wmask;

  // Third flop holds the previous synchronized level
  assign gpio_rise  = gpio_in_q & ~gpio_last_q;
  assign status_clr = (wr_en && addr_i[7:0] == `GPIO_INTR_STATUS_OFS) ?
                      wbits[`AO_NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_meta_q <= '0;
      gpio_in_q   <= '0;
      gpio_last_q <= '0;
      out_q       <= '0;
      out_en_q    <= '0;
      intr_en_q   <= '0;
      status_q    <= '0;
    end else begin
      gpio_meta_q <= cio_gpio_i;
      gpio_in_q   <= gpio_meta_q;
      gpio_last_q <= gpio_in_q;
      status_q    <= (status_q & ~status_clr) | gpio_rise;
      if (wr_en) begin
        case (addr_i[7:0])
          `GPIO_OUT_OFS:     out_q     <= (out_q & ~wmask[7:0]) | wbits[7:0];
          `GPIO_OUT_EN_OFS:  out_en_q  <= (out_en_q & ~wmask[7:0]) | wbits[7:0];
          `GPIO_INTR_EN_OFS: intr_en_q <= (intr_en_q & ~wmask[7:0]) | wbits[7:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (addr_i[7:0])
      `GPIO_IN_OFS:          rdata_o = ao_data_t'(gpio_in_q);
      `GPIO_OUT_OFS:         rdata_o = ao_data_t'(out_q);
      `GPIO_OUT_EN_OFS:      rdata_o = ao_data_t'(out_en_q);
      `GPIO_INTR_EN_OFS:     rdata_o = ao_data_t'(intr_en_q);
      `GPIO_INTR_STATUS_OFS: rdata_o = ao_data_t'(status_q);
      default: ;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = out_en_q;
  assign intr_gpio_o   = status_q & intr_en_q;

endmodule : gpio_ao

// File: src/obi_to_reg.sv
//**************************************************************************
// Bridge from the req/gnt/rvalid slave port to a single-cycle register bus
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module obi_to_reg
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  ao_strb_t    be_i,
  input  ao_data_t    wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output ao_data_t    rdata_o,

  output logic        reg_valid_o,
  output logic        reg_write_o,
  output ao_addr_t    reg_addr_o,
  output ao_data_t    reg_wdata_o,
  output ao_strb_t    reg_strb_o,
  input  ao_data_t    reg_rdata_i
);

  bridge_state_e state_q;

  logic     we_q;
  ao_addr_t addr_q;
  ao_strb_t be_q;
  ao_data_t wdata_q;

  // Grant only while no response is pending
  assign gnt_o = req_i && (state_q == BRIDGE_IDLE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BRIDGE_IDLE;
    end else begin
      state_q <= gnt_o ? BRIDGE_RESP : BRIDGE_IDLE;
    end
  end

  // Upper address bits were decoded by the outer interconnect
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      we_q    <= we_i;
      addr_q  <= addr_i[`AO_ADDR_W-1:0];
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  // Register access and response share the cycle after the grant
  assign reg_valid_o = (state_q == BRIDGE_RESP);
  assign reg_write_o = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign reg_strb_o  = be_q;

  assign rvalid_o = (state_q == BRIDGE_RESP);
  // Decoder already returns zero outside a valid read
  assign rdata_o  = reg_rdata_i;

endmodule : obi_to_reg

// File: src/reg_demux.sv
//**************************************************************************
// Register bus decoder, block select and read data return
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module reg_demux
  import ao_periph_pkg::*;
(
  input  logic     reg_valid_i,
  input  logic     reg_write_i,
  input  ao_addr_t reg_addr_i,
  output ao_data_t reg_rdata_o,

  output logic     soc_valid_o,
  output logic     fic_valid_o,
  output logic     gpio_valid_o,
  input  ao_data_t soc_rdata_i,
  input  ao_data_t fic_rdata_i,
  input  ao_data_t gpio_rdata_i
);

  ao_addr_t blk_base;
  logic     soc_sel;
  logic     fic_sel;
  logic     gpio_sel;
  ao_data_t rd_word;

  // Block base from bits 11 to 8
  assign blk_base = {reg_addr_i[`AO_ADDR_W-1:8], 8'h00};

  assign soc_sel  = (blk_base == `AO_SOC_CTRL_BASE);
  assign fic_sel  = (blk_base == `AO_FAST_INTR_BASE);
  assign gpio_sel = (blk_base == `AO_GPIO_BASE);

  // Unmapped offsets reach no block, so writes there are dropped
  assign soc_valid_o  = reg_valid_i && soc_sel;
  assign fic_valid_o  = reg_valid_i && fic_sel;
  assign gpio_valid_o = reg_valid_i && gpio_sel;

  always_comb begin
    rd_word = `AO_BAD_ADDR_DATA;
    if (soc_sel) begin
      rd_word = soc_rdata_i;
    end else if (fic_sel) begin
      rd_word = fic_rdata_i;
    end else if (gpio_sel) begin
      rd_word = gpio_rdata_i;
    end
  end

  // Writes return a zero word
  assign reg_rdata_o = (reg_valid_i && !reg_write_i) ? rd_word : '0;

endmodule : reg_demux

// File: src/soc_ctrl.sv
//**************************************************************************
// System control registers: exit flag and value, boot select, scratch
//**************************************************************************
`timescale 1ns/1ps
`include "ao_periph_macros.svh"

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     valid_i,
  input  logic     write_i,
  input  ao_addr_t addr_i,
  input  ao_data_t wdata_i,
  input  ao_strb_t strb_i,
  output ao_data_t rdata_o,

  input  logic     boot_select_i,
  output logic     exit_valid_o,
  output ao_data_t exit_value_o
);

  logic     wr_en;
  ao_data_t wmask;
  ao_data_t wbits;

  logic     exit_valid_q;
  ao_data_t exit_value_q;
  ao_data_t scratch_q;

  assign wr_en = valid_i && write_i;
  assign wmask = strb_mask(strb_i);
  assign wbits = wdata_i & wmask;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (addr_i[7:0])
        `SOC_EXIT_VALID_OFS: exit_valid_q <= (exit_valid_q & ~wmask[0]) | wbits[0];
        `SOC_EXIT_VALUE_OFS: exit_value_q <= (exit_value_q & ~wmask) | wbits;
        `SOC_SCRATCH_OFS:    scratch_q    <= (scratch_q & ~wmask) | wbits;
        default: ;
      endcase
    end
  end

  // Boot select is read-only, unknown offsets read 0
  always_comb begin
    rdata_o = '0;
    case (addr_i[7:0])
      `SOC_EXIT_VALID_OFS: rdata_o = ao_data_t'(exit_valid_q);
      `SOC_EXIT_VALUE_OFS: rdata_o = exit_value_q;
      `SOC_BOOT_SEL_OFS:   rdata_o = ao_data_t'(boot_select_i);
      `SOC_SCRATCH_OFS:    rdata_o = scratch_q;
      default: ;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl
